//--- filelist.f
+incdir+hw
hw/keystone_pkg.sv
hw/keystone_ifs.sv
hw/source_writer.sv
hw/lookup_pipeline.sv
hw/frame_store.sv
hw/keystone_correction.sv
test/keystone_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module keystone_tb -o keystone_sim

./obj_dir/keystone_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- test/keystone_tb.sv
////////////////////////////////////////
// Testbench for the keystone corrector
// Streams six source frames through the DUT under different
// coefficient sets and checks every output beat, the stall hold
// and the source flow control against a reference model
////////////////////////////////////////

`timescale 1ns/1ps

`include "keystone_settings.svh"

module keystone_tb;
    import keystone_pkg::*;

    localparam int FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;
    localparam int FRAME_COUNT  = 6;
    localparam int TOTAL_PIXELS = FRAME_PIXELS * FRAME_COUNT;
    // About 8 cycles per pixel over six frames plus margin
    localparam int CYCLE_LIMIT  = 20000;

    // Coefficient sets for identity, shift, scale and shear, flip, identity and shift
    localparam int CFG_A [FRAME_COUNT] = '{256, 256, 384, 256, 256, 256};
    localparam int CFG_B [FRAME_COUNT] = '{0, 0, 64, 0, 0, 0};
    localparam int CFG_C [FRAME_COUNT] = '{0, 768, 0, 0, 0, 768};
    localparam int CFG_D [FRAME_COUNT] = '{0, 0, 32, 0, 0, 0};
    localparam int CFG_E [FRAME_COUNT] = '{256, 256, 320, -256, 256, 256};
    localparam int CFG_F [FRAME_COUNT] = '{0, 0, 0, 1792, 0, 0};

    logic       clock = 1'b0;
    logic       reset;
    bus_pixel_t pixel_in;
    logic       valid_in;
    logic       start_of_frame_in;
    logic       ready_out;
    bus_pixel_t pixel_out;
    logic       valid_out;
    logic       start_of_frame_out;
    logic       end_of_line_out;
    logic       ready_in = 1'b1;
    coef_t      coef_a = coef_t'(CFG_A[0]);
    coef_t      coef_b = coef_t'(CFG_B[0]);
    coef_t      coef_c = coef_t'(CFG_C[0]);
    coef_t      coef_d = coef_t'(CFG_D[0]);
    coef_t      coef_e = coef_t'(CFG_E[0]);
    coef_t      coef_f = coef_t'(CFG_F[0]);

    integer     seed;
    integer     rand_word;
    integer     error_count;
    integer     cycle_count;
    integer     frame;
    integer     i;
    bus_pixel_t src_words [TOTAL_PIXELS];
    integer     gap_cycles [TOTAL_PIXELS];

    // Reference position of the next destination beat
    integer     dest_frame;
    integer     dest_idx;
    integer     cfg_index;
    logic       sending_last;
    logic       exp_ready;
    logic       out_transfer;
    // Output as seen at a stalled edge
    logic       stall_seen;
    bus_pixel_t held_pixel;
    logic       held_sof;
    logic       held_eol;

    keystone_correction dut0 (
        .clock              (clock),
        .reset              (reset),
        .pixel_in           (pixel_in),
        .valid_in           (valid_in),
        .start_of_frame_in  (start_of_frame_in),
        .ready_out          (ready_out),
        .pixel_out          (pixel_out),
        .valid_out          (valid_out),
        .start_of_frame_out (start_of_frame_out),
        .end_of_line_out    (end_of_line_out),
        .ready_in           (ready_in),
        .coef_a             (coef_a),
        .coef_b             (coef_b),
        .coef_c             (coef_c),
        .coef_d             (coef_d),
        .coef_e             (coef_e),
        .coef_f             (coef_f)
    );

    always #5 clock = ~clock;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // Half an LSB up, then floor to whole pixels
    function automatic integer round_lookup(input integer sum);
        return (sum + (1 << (`COEF_FRAC_BITS - 1))) >>> `COEF_FRAC_BITS;
    endfunction

    function automatic bus_pixel_t expected_pixel(input integer fr, input integer idx);
        integer     x;
        integer     y;
        integer     lx;
        integer     ly;
        integer     src;
        bus_pixel_t result;
        result = '0;
        if (fr < FRAME_COUNT) begin
            x  = idx % `FRAME_WIDTH;
            y  = idx / `FRAME_WIDTH;
            lx = round_lookup(CFG_A[fr] * x + CFG_B[fr] * y + CFG_C[fr]);
            ly = round_lookup(CFG_D[fr] * x + CFG_E[fr] * y + CFG_F[fr]);
            // Outside the frame stays black
            if (lx >= 0 && lx < `FRAME_WIDTH && ly >= 0 && ly < `FRAME_HEIGHT) begin
                src          = fr * FRAME_PIXELS + ly * `FRAME_WIDTH + lx;
                result.red   = {src_words[src].red[9:2], 2'b00};
                result.blue  = {src_words[src].blue[9:2], 2'b00};
                result.green = {src_words[src].green[9:2], 2'b00};
            end
        end
        return result;
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        error_count = error_count + 1;
        $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // One source frame of single-pixel beats with optional idle beats
    task automatic send_frame(input integer fr);
        integer px;
        integer gap;
        integer base;
        base = fr * FRAME_PIXELS;
        for (px = 0; px < FRAME_PIXELS; px++) begin
            for (gap = 0; gap < gap_cycles[base + px]; gap++) begin
                valid_in = 1'b0;
                @(negedge clock);
            end
            pixel_in          = src_words[base + px];
            start_of_frame_in = (px == 0);
            sending_last      = (px == FRAME_PIXELS - 1);
            valid_in          = 1'b1;
            // Held until ready_out lets the beat through
            while (!ready_out) begin
                @(negedge clock);
            end
            @(negedge clock);
        end
        valid_in          = 1'b0;
        start_of_frame_in = 1'b0;
        sending_last      = 1'b0;
    endtask

    // Coefficients for the next frame and a random sink in later frames
    always @(negedge clock) begin
        coef_a = coef_t'(CFG_A[cfg_index]);
        coef_b = coef_t'(CFG_B[cfg_index]);
        coef_c = coef_t'(CFG_C[cfg_index]);
        coef_d = coef_t'(CFG_D[cfg_index]);
        coef_e = coef_t'(CFG_E[cfg_index]);
        coef_f = coef_t'(CFG_F[cfg_index]);
        if (!reset && dest_frame >= 4) begin
            rand_word = $random(seed);
            ready_in  = rand_word[0];
        end else begin
            ready_in = 1'b1;
        end
    end

    assign out_transfer = valid_out && ready_in;

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            dest_frame <= 0;
            dest_idx   <= 0;
            cfg_index  <= 0;
            exp_ready  <= 1'b1;
            stall_seen <= 1'b0;
            held_pixel <= '0;
            held_sof   <= 1'b0;
            held_eol   <= 1'b0;
        end else begin
            stall_seen <= valid_out && !ready_in;
            held_pixel <= pixel_out;
            held_sof   <= start_of_frame_out;
            held_eol   <= end_of_line_out;
            if (out_transfer) begin
                // Next coefficient set goes out once the first pixel has left
                if (dest_idx == 0 && dest_frame < FRAME_COUNT - 1) begin
                    cfg_index <= dest_frame + 1;
                end
                if (dest_idx == FRAME_PIXELS - 1) begin
                    dest_idx   <= 0;
                    dest_frame <= dest_frame + 1;
                end else begin
                    dest_idx <= dest_idx + 1;
                end
            end
            // Source closed from its last pixel to the last destination pixel
            if (valid_in && ready_out && sending_last) begin
                exp_ready <= 1'b0;
            end else if (out_transfer && dest_idx == FRAME_PIXELS - 1) begin
                exp_ready <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clock) disable iff (reset)
        out_transfer |-> (pixel_out == expected_pixel(dest_frame, dest_idx)))
        else report_value("pixel_out",
                          {2'b00, expected_pixel($sampled(dest_frame), $sampled(dest_idx))},
                          {2'b00, $sampled(pixel_out)});

    assert property (@(posedge clock) disable iff (reset)
        out_transfer |-> (start_of_frame_out == (dest_idx == 0)))
        else report_value("start_of_frame_out", {31'b0, $sampled(dest_idx) == 0},
                          {31'b0, $sampled(start_of_frame_out)});

    assert property (@(posedge clock) disable iff (reset)
        out_transfer |-> (end_of_line_out == (dest_idx % `FRAME_WIDTH == `FRAME_WIDTH - 1)))
        else report_value("end_of_line_out",
                          {31'b0, $sampled(dest_idx) % `FRAME_WIDTH == `FRAME_WIDTH - 1},
                          {31'b0, $sampled(end_of_line_out)});

    // Output held while the sink stalls
    assert property (@(posedge clock) disable iff (reset) stall_seen |-> valid_out)
        else report_value("valid_out", 32'd1, {31'b0, $sampled(valid_out)});

    assert property (@(posedge clock) disable iff (reset)
        stall_seen |-> pixel_out == held_pixel)
        else report_value("pixel_out", {2'b00, $sampled(held_pixel)},
                          {2'b00, $sampled(pixel_out)});

    assert property (@(posedge clock) disable iff (reset)
        stall_seen |-> start_of_frame_out == held_sof)
        else report_value("start_of_frame_out", {31'b0, $sampled(held_sof)},
                          {31'b0, $sampled(start_of_frame_out)});

    assert property (@(posedge clock) disable iff (reset)
        stall_seen |-> end_of_line_out == held_eol)
        else report_value("end_of_line_out", {31'b0, $sampled(held_eol)},
                          {31'b0, $sampled(end_of_line_out)});

    assert property (@(posedge clock) disable iff (reset) ready_out == exp_ready)
        else report_value("ready_out", {31'b0, $sampled(exp_ready)},
                          {31'b0, $sampled(ready_out)});

    // Run limit
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: only %0d frames came out within %0d cycles",
                     dest_frame, CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "run aborted");
        end
    end

    initial begin
        seed              = 64;
        error_count       = 0;
        cycle_count       = 0;
        reset             = 1'b1;
        valid_in          = 1'b0;
        start_of_frame_in = 1'b0;
        sending_last      = 1'b0;
        pixel_in          = '0;

        // Random source pixels and idle beats from frame 3 on
        for (i = 0; i < TOTAL_PIXELS; i++) begin
            frame        = i / FRAME_PIXELS;
            rand_word    = $random(seed);
            src_words[i] = rand_word[29:0];
            if (frame == 3) begin
                gap_cycles[i] = $random(seed) & 3;
            end else if (frame > 3) begin
                gap_cycles[i] = $random(seed) & 1;
            end else begin
                gap_cycles[i] = 0;
            end
        end

        repeat (8) @(negedge clock);
        reset = 1'b0;

        for (frame = 0; frame < FRAME_COUNT; frame++) begin
            send_frame(frame);
        end
        wait (dest_frame == FRAME_COUNT);
        @(negedge clock);

        // Source side open again after the last frame
        assert (ready_out == 1'b1)
            else report_value("ready_out", 32'd1, {31'b0, ready_out});

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "errors found");
        end
    end

endmodule

//--- hw/keystone_correction.sv
////////////////////////////////////////
// Keystone corrector top level
// Source pixels stream in, are stored whole-frame and leave warped by
// the affine coefficients a to f, latched at each destination frame.
// Out-of-frame lookups come out black.
////////////////////////////////////////

`timescale 1ns/1ps

module keystone_correction (
    input  logic                     clock,
    input  logic                     reset,
    // Source stream
    input  keystone_pkg::bus_pixel_t pixel_in,
    input  logic                     valid_in,
    input  logic                     start_of_frame_in,
    output logic                     ready_out,
    // Destination stream
    output keystone_pkg::bus_pixel_t pixel_out,
    output logic                     valid_out,
    output logic                     start_of_frame_out,
    output logic                     end_of_line_out,
    input  logic                     ready_in,
    // Transform coefficients, Q8.8
    input  keystone_pkg::coef_t      coef_a,
    input  keystone_pkg::coef_t      coef_b,
    input  keystone_pkg::coef_t      coef_c,
    input  keystone_pkg::coef_t      coef_d,
    input  keystone_pkg::coef_t      coef_e,
    input  keystone_pkg::coef_t      coef_f
);

    logic dest_frame_done;

    store_write_if write_bus ();
    lookup_if      lookup_bus ();

    // Input side and write position
    source_writer writer0 (
        .clock             (clock),
        .reset             (reset),
        .pixel_in          (pixel_in),
        .valid_in          (valid_in),
        .start_of_frame_in (start_of_frame_in),
        .ready_out         (ready_out),
        .dest_frame_done   (dest_frame_done),
        .write             (write_bus.source)
    );

    // Destination scan and transform
    lookup_pipeline pipe0 (
        .clock  (clock),
        .reset  (reset),
        .coef_a (coef_a),
        .coef_b (coef_b),
        .coef_c (coef_c),
        .coef_d (coef_d),
        .coef_e (coef_e),
        .coef_f (coef_f),
        .lookup (lookup_bus.pipeline)
    );

    // Frame memory and output stream
    frame_store store0 (
        .clock              (clock),
        .reset              (reset),
        .write              (write_bus.sink),
        .lookup             (lookup_bus.store),
        .pixel_out          (pixel_out),
        .valid_out          (valid_out),
        .start_of_frame_out (start_of_frame_out),
        .end_of_line_out    (end_of_line_out),
        .ready_in           (ready_in),
        .dest_frame_done    (dest_frame_done)
    );

endmodule

//--- hw/frame_store.sv
////////////////////////////////////////
// Whole-frame pixel store and output stage
// Written by the source side, read at the pipeline head on advance.
// Decides when a lookup may proceed and drives the output stream.
////////////////////////////////////////

`timescale 1ns/1ps

`include "keystone_settings.svh"

module frame_store (
    input  logic                     clock,
    input  logic                     reset,
    store_write_if.sink              write,
    lookup_if.store                  lookup,
    output keystone_pkg::bus_pixel_t pixel_out,
    output logic                     valid_out,
    output logic                     start_of_frame_out,
    output logic                     end_of_line_out,
    input  logic                     ready_in,
    output logic                     dest_frame_done
);
    import keystone_pkg::*;

    localparam int     ADDR_BITS  = $clog2(`STORE_DEPTH);
    localparam color_t FILL_COLOR = '{red: 8'd0, green: 8'd0, blue: 8'd0};
    localparam coord_t LAST_ROW   = coord_t'(`FRAME_HEIGHT - 1);

    typedef logic [ADDR_BITS-1:0] addr_t;

    color_t pixels [`STORE_DEPTH];
    color_t color_q;
    logic   last_q;
    coord_t issue_row;
    coord_t head_x;
    coord_t head_y;
    logic   precedes;
    logic   finishing;
    logic   transfer;

    function automatic addr_t store_address(input coord_t x, input coord_t y);
        return addr_t'(y * `FRAME_WIDTH + x);
    endfunction

    always_ff @(posedge clock) begin
        if (write.write_strobe) begin
            pixels[store_address(write.write_x, write.write_y)] <= write.write_color;
        end
    end

    ////////////////////////////////////////
    // Availability
    ////////////////////////////////////////

    // Only meaningful for in-frame items
    assign head_x = coord_t'(lookup.lookup_x);
    assign head_y = coord_t'(lookup.lookup_y);

    // Already written this frame
    assign precedes = (head_y < write.write_y) ||
                      ((head_y == write.write_y) && (head_x < write.write_x));

    // Last pixel still waiting in the output registers
    // so the complete source frame belongs to the frame being finished
    assign finishing = valid_out && last_q;

    assign lookup.available = !lookup.in_frame ||
                              (write.source_frame_complete && !finishing) ||
                              precedes;

    assign lookup.accept = !valid_out || ready_in;

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (lookup.advance) begin
            color_q <= lookup.in_frame ? pixels[store_address(head_x, head_y)] : FILL_COLOR;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out          <= 1'b0;
            start_of_frame_out <= 1'b0;
            end_of_line_out    <= 1'b0;
            last_q             <= 1'b0;
            issue_row          <= '0;
        end else if (lookup.advance) begin
            valid_out          <= lookup.lookup_valid;
            start_of_frame_out <= lookup.dest_first;
            end_of_line_out    <= lookup.dest_row_end;
            last_q             <= lookup.lookup_valid && lookup.dest_row_end &&
                                  (issue_row == LAST_ROW);
            // Destination row of the head item
            if (lookup.lookup_valid && lookup.dest_row_end) begin
                issue_row <= (issue_row == LAST_ROW) ? '0 : issue_row + coord_t'(1);
            end
        end else if (ready_in) begin
            valid_out <= 1'b0;
        end
    end

    assign transfer        = valid_out && ready_in;
    assign dest_frame_done = transfer && last_q;

    // Colour in the top 8 bits of each 10 bit field
    assign pixel_out = '{red:   {color_q.red,   2'b00},
                         blue:  {color_q.blue,  2'b00},
                         green: {color_q.green, 2'b00}};

endmodule

//--- hw/lookup_pipeline.sv
////////////////////////////////////////
// Affine transform pipeline
// Scans destination pixels in raster order and turns each into a
// rounded source lookup. Two stages, products then rounding, both
// moving only on advance. Coefficients are taken at pixel (0,0).
////////////////////////////////////////

`timescale 1ns/1ps

`include "keystone_settings.svh"

module lookup_pipeline (
    input  logic                clock,
    input  logic                reset,
    input  keystone_pkg::coef_t coef_a,
    input  keystone_pkg::coef_t coef_b,
    input  keystone_pkg::coef_t coef_c,
    input  keystone_pkg::coef_t coef_d,
    input  keystone_pkg::coef_t coef_e,
    input  keystone_pkg::coef_t coef_f,
    lookup_if.pipeline          lookup
);
    import keystone_pkg::*;

    // Signed coefficient times a 9 bit signed coordinate
    localparam int PROD_BITS  = `COEF_BITS + `COORD_BITS + 1;
    // Room for two products, the offset and the rounding half
    localparam int SUM_BITS   = PROD_BITS + 2;
    localparam int ROUND_HALF = 1 << (`COEF_FRAC_BITS - 1);

    localparam coord_t LAST_X = coord_t'(`FRAME_WIDTH - 1);
    localparam coord_t LAST_Y = coord_t'(`FRAME_HEIGHT - 1);

    typedef logic signed [PROD_BITS-1:0] product_t;
    typedef logic signed [SUM_BITS-1:0]  sum_t;

    coord_t dest_x;
    coord_t dest_y;
    logic   issue_first;
    coef_t  a_q, b_q, c_q, d_q, e_q, f_q;
    coef_t  a_use, b_use, c_use, d_use, e_use, f_use;

    // Stage one
    logic     s1_valid;
    logic     s1_first;
    logic     s1_row_end;
    product_t ax_q, by_q, dx_q, ey_q;
    coef_t    c_s1, f_s1;

    // Stage two
    logic          s2_valid;
    logic          s2_first;
    logic          s2_row_end;
    logic          s2_in_frame;
    lookup_coord_t s2_x;
    lookup_coord_t s2_y;
    sum_t          x_full;
    sum_t          y_full;

    function automatic product_t scale(input coef_t coef, input coord_t pos);
        return coef * $signed({1'b0, pos});
    endfunction

    // Round half up, then drop the fraction
    function automatic sum_t round_fixed(input product_t p0, input product_t p1,
                                         input coef_t offset);
        sum_t total;
        total = sum_t'(p0) + sum_t'(p1) + sum_t'(offset) + sum_t'(ROUND_HALF);
        return total >>> `COEF_FRAC_BITS;
    endfunction

    // One enable for the whole pipe
    assign lookup.advance = lookup.accept &&
                            (!s2_valid || !s2_in_frame || lookup.available);

    ////////////////////////////////////////
    // Destination scan
    ////////////////////////////////////////

    assign issue_first = (dest_x == '0) && (dest_y == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dest_x <= '0;
            dest_y <= '0;
        end else if (lookup.advance) begin
            if (dest_x == LAST_X) begin
                dest_x <= '0;
                dest_y <= (dest_y == LAST_Y) ? '0 : dest_y + coord_t'(1);
            end else begin
                dest_x <= dest_x + coord_t'(1);
            end
        end
    end

    // The first pixel of a frame already uses the new coefficients
    assign a_use = issue_first ? coef_a : a_q;
    assign b_use = issue_first ? coef_b : b_q;
    assign c_use = issue_first ? coef_c : c_q;
    assign d_use = issue_first ? coef_d : d_q;
    assign e_use = issue_first ? coef_e : e_q;
    assign f_use = issue_first ? coef_f : f_q;

    always_ff @(posedge clock) begin
        if (lookup.advance && issue_first) begin
            a_q <= coef_a;
            b_q <= coef_b;
            c_q <= coef_c;
            d_q <= coef_d;
            e_q <= coef_e;
            f_q <= coef_f;
        end
    end

    ////////////////////////////////////////
    // Products and rounding
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (lookup.advance) begin
            // Scanner issues on every advance
            s1_valid <= 1'b1;
            s2_valid <= s1_valid;
        end
    end

    assign x_full = round_fixed(ax_q, by_q, c_s1);
    assign y_full = round_fixed(dx_q, ey_q, f_s1);

    always_ff @(posedge clock) begin
        if (lookup.advance) begin
            ax_q       <= scale(a_use, dest_x);
            by_q       <= scale(b_use, dest_y);
            dx_q       <= scale(d_use, dest_x);
            ey_q       <= scale(e_use, dest_y);
            // Offsets travel with their item across a frame change
            c_s1       <= c_use;
            f_s1       <= f_use;
            s1_first   <= issue_first;
            s1_row_end <= (dest_x == LAST_X);

            s2_x        <= lookup_coord_t'(x_full);
            s2_y        <= lookup_coord_t'(y_full);
            // Range judged on the full sum, not the narrowed one
            s2_in_frame <= (x_full >= 0) && (x_full < `FRAME_WIDTH) &&
                           (y_full >= 0) && (y_full < `FRAME_HEIGHT);
            s2_first    <= s1_first;
            s2_row_end  <= s1_row_end;
        end
    end

    assign lookup.lookup_valid = s2_valid;
    assign lookup.lookup_x     = s2_x;
    assign lookup.lookup_y     = s2_y;
    assign lookup.in_frame     = s2_in_frame;
    assign lookup.dest_first   = s2_first;
    assign lookup.dest_row_end = s2_row_end;

endmodule

//--- hw/source_writer.sv
////////////////////////////////////////
// Source side of the keystone corrector
// Takes one pixel per beat, tracks its raster position and
// writes it into the frame store in the cycle it is accepted.
// Holds the stream off once a full frame is stored.
////////////////////////////////////////

`timescale 1ns/1ps

`include "keystone_settings.svh"

module source_writer (
    input  logic                     clock,
    input  logic                     reset,
    input  keystone_pkg::bus_pixel_t pixel_in,
    input  logic                     valid_in,
    input  logic                     start_of_frame_in,
    output logic                     ready_out,
    input  logic                     dest_frame_done,
    store_write_if.source            write
);
    import keystone_pkg::*;

    localparam coord_t LAST_X = coord_t'(`FRAME_WIDTH - 1);
    localparam coord_t LAST_Y = coord_t'(`FRAME_HEIGHT - 1);

    coord_t col_count;
    coord_t row_count;
    coord_t col_now;
    coord_t row_now;
    logic   accepted;
    logic   last_pixel;
    logic   frame_complete;

    assign accepted = valid_in && ready_out;

    // Start of frame restarts the raster for this very beat
    assign col_now = (accepted && start_of_frame_in) ? '0 : col_count;
    assign row_now = (accepted && start_of_frame_in) ? '0 : row_count;

    assign last_pixel = accepted && (col_now == LAST_X) && (row_now == LAST_Y);

    ////////////////////////////////////////
    // Write position
    ////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            col_count <= '0;
            row_count <= '0;
        end else if (accepted) begin
            if (col_now == LAST_X) begin
                col_count <= '0;
                // Wraps to the top after the last row
                row_count <= (row_now == LAST_Y) ? '0 : row_now + coord_t'(1);
            end else begin
                col_count <= col_now + coord_t'(1);
                row_count <= row_now;
            end
        end
    end

    // Set by the last pixel, cleared once the destination frame has left
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            frame_complete <= 1'b0;
        end else if (last_pixel) begin
            frame_complete <= 1'b1;
        end else if (dest_frame_done) begin
            frame_complete <= 1'b0;
        end
    end

    assign ready_out = !frame_complete;

    // Store side
    assign write.write_strobe = accepted;
    assign write.write_x      = col_now;
    assign write.write_y      = row_now;
    // Low two bits of each field are dropped
    assign write.write_color  = '{red:   pixel_in.red[9:2],
                                  green: pixel_in.green[9:2],
                                  blue:  pixel_in.blue[9:2]};
    assign write.source_frame_complete = frame_complete;

endmodule

//--- hw/keystone_ifs.sv
////////////////////////////////////////
// Internal buses of the keystone corrector
// store_write_if carries source writes into the frame store
// lookup_if joins the transform pipeline head to the frame store
////////////////////////////////////////

`timescale 1ns/1ps

interface store_write_if;
    import keystone_pkg::*;

    logic   write_strobe;
    coord_t write_x;
    coord_t write_y;
    color_t write_color;
    // High from the last source pixel until the destination frame is out
    logic   source_frame_complete;

    modport source (
        output write_strobe, write_x, write_y, write_color, source_frame_complete
    );

    modport sink (
        input write_strobe, write_x, write_y, write_color, source_frame_complete
    );
endinterface

interface lookup_if;
    import keystone_pkg::*;

    // Head item of the transform pipeline
    logic          lookup_valid;
    lookup_coord_t lookup_x;
    lookup_coord_t lookup_y;
    logic          in_frame;
    logic          dest_first;
    logic          dest_row_end;
    // Head moves into the output registers
    logic          advance;
    // Handshake back from the store
    logic          available;
    logic          accept;

    modport pipeline (
        output lookup_valid, lookup_x, lookup_y, in_frame, dest_first, dest_row_end,
        output advance,
        input  available, accept
    );

    modport store (
        input  lookup_valid, lookup_x, lookup_y, in_frame, dest_first, dest_row_end,
        input  advance,
        output available, accept
    );
endinterface

//--- hw/keystone_pkg.sv
////////////////////////////////////////
// Shared types for the keystone corrector
// Colour, bus pixel, coordinate and coefficient formats
////////////////////////////////////////

`include "keystone_settings.svh"

package keystone_pkg;

    // Destination and write positions
    typedef logic [`COORD_BITS-1:0] coord_t;

    // Two extra bits so negative and overflowing lookups show up
    typedef logic signed [`COORD_BITS+1:0] lookup_coord_t;

    // Signed fixed point, 8 integer and 8 fraction bits
    typedef logic signed [`COEF_BITS-1:0] coef_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } color_t;

    // Stream layout, top 8 bits of each field carry the colour
    typedef struct packed {
        logic [9:0] red;
        logic [9:0] blue;
        logic [9:0] green;
    } bus_pixel_t;

endpackage

//--- hw/keystone_settings.svh
////////////////////////////////////////
// Build-time settings for the keystone corrector
// Frame geometry and coefficient format shared by the package and RTL
// Include this file wherever one of these values is needed
////////////////////////////////////////

`ifndef KEYSTONE_SETTINGS_SVH
`define KEYSTONE_SETTINGS_SVH

// Frame size in pixels
`define FRAME_WIDTH    16
`define FRAME_HEIGHT   8

// Unsigned pixel coordinate width
`define COORD_BITS     8

// Coefficients are signed Q8.8
`define COEF_BITS      16
`define COEF_FRAC_BITS 8

// One colour per source pixel in the frame store
`define STORE_DEPTH    (`FRAME_WIDTH * `FRAME_HEIGHT)

`endif
